/* list.f */
csr_cfg_pkg.sv
csr_isa_pkg.sv
csr_decode.sv
csr_file.sv
csr_execute.sv
csr_result.sv
csr_unit.sv
tb_csr_unit.sv

/* Makefile */
TOP := tb_csr_unit
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f list.f

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

/* tb_csr_unit.sv */
module tb_csr_unit
    import csr_cfg_pkg::*;
    import csr_isa_pkg::*;
;

    localparam int MAX_CYCLES = 3000; // Stimulus runs about 1200

    logic              clk;
    logic              rst_n;
    logic              req_i;
    logic [2:0]        funct3_i;
    logic [ADDR_W-1:0] addr_i;
    logic [IDX_W-1:0]  src_idx_i;
    logic [XLEN-1:0]   rs1_val_i;
    logic              retire_i;
    logic              rd_valid_o;
    logic [XLEN-1:0]   rd_data_o;
    logic              illegal_o;

    // Reference model
    logic [XLEN-1:0]   m_scratch;
    logic [CNT_W-1:0]  m_cycle;
    logic [CNT_W-1:0]  m_instret;
    logic              s1_valid;    // Request in decode
    logic [2:0]        s1_f3;
    logic [ADDR_W-1:0] s1_addr;
    logic [IDX_W-1:0]  s1_idx;
    logic [XLEN-1:0]   s1_rs1;
    logic [XLEN:0]     exp_q[$];    // {illegal, rd data}
    logic              exp_ill_q;
    logic [XLEN-1:0]   exp_data_q;
    logic              req_d1;
    logic              req_d2;      // Response slot of a request
    int                pending;
    int                cycles = 0;

    csr_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic addr_known(input logic [ADDR_W-1:0] a);
        return a inside {12'h340, 12'hB00, 12'hB02, 12'hB80, 12'hB82,
                         12'hC00, 12'hC02, 12'hC80, 12'hC82};
    endfunction

    // Current model value behind an address
    function automatic logic [XLEN-1:0] csr_value(input logic [ADDR_W-1:0] a);
        case (a)
            12'h340:          return m_scratch;
            12'hB00, 12'hC00: return m_cycle[31:0];
            12'hB80, 12'hC80: return m_cycle[63:32];
            12'hB02, 12'hC02: return m_instret[31:0];
            12'hB82, 12'hC82: return m_instret[63:32];
            default:          return '0;
        endcase
    endfunction

    // x0 or zimm 0 about a quarter of the time
    function automatic logic [IDX_W-1:0] pick_idx();
        if ($urandom_range(3, 0) == 0) return '0;
        return IDX_W'($urandom_range(31, 1));
    endfunction

    always @(posedge clk or negedge rst_n) begin : ref_model
        logic [XLEN-1:0]  old_v;
        logic [XLEN-1:0]  opnd;
        logic [XLEN-1:0]  new_v;
        logic             ill;
        logic             wr;
        logic [CNT_W-1:0] cyc_n;
        logic [CNT_W-1:0] ret_n;
        logic [XLEN:0]    head;
        if (!rst_n) begin
            m_scratch  <= '0;
            m_cycle    <= '0;
            m_instret  <= '0;
            s1_valid   <= 1'b0;
            exp_ill_q  <= 1'b0;
            exp_data_q <= '0;
            exp_q.delete();
        end else begin
            cyc_n = m_cycle + 64'd1;                 // Free running
            ret_n = m_instret + {63'd0, retire_i};
            if (s1_valid) begin                      // Execute cycle
                old_v = csr_value(s1_addr);
                opnd  = s1_f3[2] ? {{(XLEN-IDX_W){1'b0}}, s1_idx} : s1_rs1;
                wr    = (s1_f3[1:0] == 2'd1) || (s1_idx != '0);
                ill   = (s1_f3[1:0] == 2'd0) || !addr_known(s1_addr)
                        || (wr && s1_addr[11:10] == 2'b11); // Read-only space
                case (s1_f3[1:0])
                    2'd1:    new_v = opnd;
                    2'd2:    new_v = old_v | opnd;
                    default: new_v = old_v & ~opnd;
                endcase
                if (wr && !ill) begin                // Write beats increment
                    case (s1_addr)
                        12'h340: m_scratch <= new_v;
                        12'hB00: cyc_n = {m_cycle[63:32], new_v};
                        12'hB80: cyc_n = {new_v, m_cycle[31:0]};
                        12'hB02: ret_n = {m_instret[63:32], new_v};
                        12'hB82: ret_n = {new_v, m_instret[31:0]};
                        default: ;
                    endcase
                end
                exp_q.push_back({ill, (ill ? {XLEN{1'b0}} : old_v)});
            end
            m_cycle   <= cyc_n;
            m_instret <= ret_n;
            if (exp_q.size() > 0) begin              // Head shown next cycle
                head = exp_q.pop_front();
                exp_ill_q  <= head[XLEN];
                exp_data_q <= head[XLEN-1:0];
            end
            s1_valid <= req_i;
            s1_f3    <= funct3_i;
            s1_addr  <= addr_i;
            s1_idx   <= src_idx_i;
            s1_rs1   <= rs1_val_i;
        end
    end

    // Request strobe delayed by two edges and the in-flight count
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_d1  <= 1'b0;
            req_d2  <= 1'b0;
            pending <= 0;
        end else begin
            req_d1  <= req_i;
            req_d2  <= req_d1;
            pending <= pending + int'(req_i) - int'(rd_valid_o);
        end
    end

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
        $display("FAIL: see errors above");
        $fatal(1, "mismatch on %s", name);
    endtask

    a_latency: assert property (@(posedge clk) disable iff (!rst_n) rd_valid_o == req_d2)
        else value_error("rd_valid_o", {31'd0, $sampled(req_d2)}, {31'd0, $sampled(rd_valid_o)});
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
                             rd_valid_o |-> rd_data_o == exp_data_q)
        else value_error("rd_data_o", $sampled(exp_data_q), $sampled(rd_data_o));
    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
                                rd_valid_o |-> illegal_o == exp_ill_q)
        else value_error("illegal_o", {31'd0, $sampled(exp_ill_q)},
                         {31'd0, $sampled(illegal_o)});

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    // One clock of inputs
    task automatic drive(input logic req, input logic [2:0] f3, input logic [ADDR_W-1:0] addr,
                         input logic [IDX_W-1:0] idx, input logic [XLEN-1:0] val,
                         input logic ret);
        @(posedge clk);
        req_i     <= req;
        funct3_i  <= f3;
        addr_i    <= addr;
        src_idx_i <= idx;
        rs1_val_i <= val;
        retire_i  <= ret;
    endtask

    task automatic issue(input logic [2:0] f3, input logic [ADDR_W-1:0] addr,
                         input logic [IDX_W-1:0] idx, input logic [XLEN-1:0] val);
        drive(1'b1, f3, addr, idx, val, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) drive(1'b0, 3'd0, '0, '0, '0, 1'b0);
    endtask

    initial begin
        logic [ADDR_W-1:0] bad_addr [6];
        logic [ADDR_W-1:0] mix_addr [9];
        logic [ADDR_W-1:0] chk_addr;
        bad_addr = '{12'h000, 12'h300, 12'h341, 12'hB01, 12'hC01, 12'hFFF};
        mix_addr = '{12'h340, 12'h340, 12'hB00, 12'hB80, 12'hB02, 12'hB82,
                     12'hC00, 12'hC82, 12'h7C0};
        void'($urandom(9));
        rst_n     = 1'b0;
        req_i     = 1'b0;
        funct3_i  = '0;
        addr_i    = '0;
        src_idx_i = '0;
        rs1_val_i = '0;
        retire_i  = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        repeat (150) begin // Register forms on mscratch
            issue(3'($urandom_range(3, 1)), CSR_MSCRATCH, pick_idx(), $urandom());
            idle($urandom_range(2, 0));
        end
        repeat (100) begin // Immediate forms with the rs1 value ignored
            issue(3'($urandom_range(7, 5)), CSR_MSCRATCH, pick_idx(), $urandom());
            idle($urandom_range(1, 0));
        end

        // Cycle write near the carry and reads after 1 to 4 cycles
        for (int r = 0; r < 8; r++) begin
            issue(F3_CSRRW, (r % 2 == 0) ? CSR_MCYCLE : CSR_MCYCLEH, 5'd1,
                  (r < 4) ? ~32'(r) : $urandom());
            for (int gap = 1; gap <= 4; gap++) begin
                idle(gap - 1);
                issue(F3_CSRRS, CSR_MCYCLE, 5'd0, '0);
                idle(gap - 1);
                issue(F3_CSRRS, CSR_CYCLE, 5'd0, '0);
                issue(F3_CSRRSI, CSR_CYCLEH, 5'd0, '0);
            end
        end

        repeat (40) begin // Retire pulses between instret reads
            repeat ($urandom_range(6, 1)) drive(1'b0, 3'd0, '0, '0, '0, 1'($urandom_range(1, 0)));
            drive(1'b1, F3_CSRRS, CSR_MINSTRET, 5'd0, '0, 1'($urandom_range(1, 0)));
            drive(1'b1, F3_CSRRC, CSR_INSTRETH, 5'd0, '0, 1'b1);
        end
        repeat (10) begin
            drive(1'b1, F3_CSRRW, CSR_MINSTRET, 5'd3, ~32'($urandom_range(3, 0)), 1'b1);
            drive(1'b0, 3'd0, '0, '0, '0, 1'b1);  // Pulse lands with the write
            drive(1'b1, F3_CSRRWI, CSR_MINSTRETH, IDX_W'($urandom_range(31, 0)), '0, 1'b1);
            drive(1'b1, F3_CSRRS, CSR_INSTRET, 5'd0, '0, 1'b1);
            idle(1);
        end

        repeat (30) begin // Illegal request and a read of the state it aims at
            case ($urandom_range(3, 0))
                0: begin
                    issue(3'($urandom_range(1, 0) * 4), CSR_MSCRATCH, pick_idx(), $urandom());
                    chk_addr = CSR_MSCRATCH;
                end
                1: begin
                    issue(3'($urandom_range(3, 1)), bad_addr[$urandom_range(5, 0)],
                          pick_idx(), $urandom());
                    chk_addr = CSR_MSCRATCH;
                end
                2: begin
                    issue(F3_CSRRW, CSR_CYCLE, pick_idx(), $urandom());
                    chk_addr = CSR_MCYCLE;
                end
                default: begin
                    issue(F3_CSRRSI, CSR_INSTRETH, IDX_W'($urandom_range(31, 1)), '0);
                    chk_addr = CSR_MINSTRETH;
                end
            endcase
            issue(F3_CSRRS, chk_addr, 5'd0, '0);
            idle(1);
        end
        issue(F3_CSRRS, CSR_CYCLEH, 5'd0, $urandom()); // x0 on a shadow is legal

        repeat (200) begin // Back-to-back mix
            drive(1'b1, 3'($urandom_range(7, 0)), mix_addr[$urandom_range(8, 0)], pick_idx(),
                  $urandom(), 1'($urandom_range(1, 0)));
        end
        idle(1);

        do @(posedge clk); while (pending != 0);
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* csr_unit.sv */
module csr_unit
    import csr_cfg_pkg::*;
    import csr_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_i,
    input  logic [2:0]        funct3_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [IDX_W-1:0]  src_idx_i,
    input  logic [XLEN-1:0]   rs1_val_i,
    input  logic              retire_i,
    output logic              rd_valid_o,
    output logic [XLEN-1:0]   rd_data_o,
    output logic              illegal_o
);

    // Decode to execute
    logic            dec_valid;
    csr_kind_e       dec_kind;
    csr_sel_e        dec_sel;
    logic [XLEN-1:0] dec_operand;
    logic            dec_wr;
    logic            dec_illegal;

    // Execute and file
    csr_sel_e        rd_sel;
    logic [XLEN-1:0] rd_val;
    logic            wr_en;
    csr_sel_e        wr_sel;
    logic [XLEN-1:0] wr_data;

    // Execute to result
    logic            ex_valid;
    logic [XLEN-1:0] ex_old;
    logic            ex_illegal;

    csr_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_i),
        .funct3_i  (funct3_i),
        .addr_i    (addr_i),
        .src_idx_i (src_idx_i),
        .rs1_val_i (rs1_val_i),
        .valid_o   (dec_valid),
        .kind_o    (dec_kind),
        .sel_o     (dec_sel),
        .operand_o (dec_operand),
        .wr_o      (dec_wr),
        .illegal_o (dec_illegal)
    );

    csr_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (dec_valid),
        .kind_i    (dec_kind),
        .sel_i     (dec_sel),
        .operand_i (dec_operand),
        .wr_i      (dec_wr),
        .illegal_i (dec_illegal),
        .rd_val_i  (rd_val),
        .rd_sel_o  (rd_sel),
        .wr_en_o   (wr_en),
        .wr_sel_o  (wr_sel),
        .wr_data_o (wr_data),
        .valid_o   (ex_valid),
        .old_o     (ex_old),
        .illegal_o (ex_illegal)
    );

    csr_file u_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .retire_i  (retire_i),
        .rd_sel_i  (rd_sel),
        .wr_en_i   (wr_en),
        .wr_sel_i  (wr_sel),
        .wr_data_i (wr_data),
        .rd_val_o  (rd_val)
    );

    csr_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (ex_valid),
        .old_i      (ex_old),
        .illegal_i  (ex_illegal),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .illegal_o  (illegal_o)
    );

endmodule

/* csr_result.sv */
module csr_result
    import csr_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_i,
    input  logic [XLEN-1:0] old_i,
    input  logic            illegal_i,
    output logic            rd_valid_o,
    output logic [XLEN-1:0] rd_data_o,
    output logic            illegal_o
);

    logic rd_valid_q;

    // One response per execute cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_i;
        end
    end

    assign rd_valid_o = rd_valid_q;

    // Illegal request returns zero in rd
    assign rd_data_o = (rd_valid_q && !illegal_i) ? old_i : '0;
    assign illegal_o = rd_valid_q && illegal_i; // Only with the strobe

endmodule

/* csr_execute.sv */
module csr_execute
    import csr_cfg_pkg::*;
    import csr_isa_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_i,
    input  csr_kind_e       kind_i,
    input  csr_sel_e        sel_i,
    input  logic [XLEN-1:0] operand_i,
    input  logic            wr_i,
    input  logic            illegal_i,
    input  logic [XLEN-1:0] rd_val_i,
    output csr_sel_e        rd_sel_o,
    output logic            wr_en_o,
    output csr_sel_e        wr_sel_o,
    output logic [XLEN-1:0] wr_data_o,
    output logic            valid_o,
    output logic [XLEN-1:0] old_o,
    output logic            illegal_o
);

    logic [XLEN-1:0] new_val;
    logic [XLEN-1:0] old_q;
    logic            illegal_q;

    assign rd_sel_o = sel_i; // Read in the execute cycle

    // Write, set or clear against the old value
    always_comb begin
        case (kind_i)
            KIND_WRITE: new_val = operand_i;
            KIND_SET:   new_val = rd_val_i | operand_i;
            KIND_CLEAR: new_val = rd_val_i & ~operand_i;
            default:    new_val = operand_i;
        endcase
    end

    // Write lands at the end of this cycle
    assign wr_en_o   = valid_i && wr_i;
    assign wr_sel_o  = sel_i;
    assign wr_data_o = new_val;

    // Strobe goes on to the result stage register
    assign valid_o = valid_i;

    // Legality held with the old value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            illegal_q <= 1'b0;
        end else if (valid_i) begin
            illegal_q <= illegal_i;
        end
    end

    // Old value before the write, held for rd
    always_ff @(posedge clk) begin
        if (valid_i) begin
            old_q <= rd_val_i;
        end
    end

    assign old_o     = old_q;
    assign illegal_o = illegal_q;

endmodule

/* csr_file.sv */
module csr_file
    import csr_cfg_pkg::*;
    import csr_isa_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            retire_i,
    input  csr_sel_e        rd_sel_i,
    input  logic            wr_en_i,
    input  csr_sel_e        wr_sel_i,
    input  logic [XLEN-1:0] wr_data_i,
    output logic [XLEN-1:0] rd_val_o
);

    logic [XLEN-1:0]  mscratch_q;
    logic [CNT_W-1:0] cycle_q;
    logic [CNT_W-1:0] instret_q;

    logic             wr_scratch;
    logic             wr_cyc_lo;
    logic             wr_cyc_hi;
    logic             wr_ret_lo;
    logic             wr_ret_hi;

    // Next counter value, a half write wins over the increment
    function automatic logic [CNT_W-1:0] cnt_next(
        input logic [CNT_W-1:0] cur,
        input logic             wr_lo,
        input logic             wr_hi,
        input logic [XLEN-1:0]  data,
        input logic             inc
    );
        logic [CNT_W-1:0] nxt;
        nxt = cur;
        if (wr_lo) begin
            nxt = {cur[CNT_W-1:XLEN], data}; // High half untouched
        end else if (wr_hi) begin
            nxt = {data, cur[XLEN-1:0]};
        end else if (inc) begin
            nxt = cur + 1'b1;
        end
        return nxt;
    endfunction

    // Write decode
    assign wr_scratch = wr_en_i && (wr_sel_i == SEL_SCRATCH);
    assign wr_cyc_lo  = wr_en_i && (wr_sel_i == SEL_CYC_LO);
    assign wr_cyc_hi  = wr_en_i && (wr_sel_i == SEL_CYC_HI);
    assign wr_ret_lo  = wr_en_i && (wr_sel_i == SEL_RET_LO);
    assign wr_ret_hi  = wr_en_i && (wr_sel_i == SEL_RET_HI);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch_q <= '0;
        end else if (wr_scratch) begin
            mscratch_q <= wr_data_i;
        end
    end

    // Cycle counter runs every clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cnt_next(cycle_q, wr_cyc_lo, wr_cyc_hi, wr_data_i, 1'b1);
        end
    end

    // Instret counter follows retire pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret_q <= '0;
        end else begin
            instret_q <= cnt_next(instret_q, wr_ret_lo, wr_ret_hi, wr_data_i, retire_i);
        end
    end

    // Read mux, same cycle as the select
    always_comb begin
        case (rd_sel_i)
            SEL_SCRATCH: rd_val_o = mscratch_q;
            SEL_CYC_LO:  rd_val_o = cycle_q[XLEN-1:0];
            SEL_CYC_HI:  rd_val_o = cycle_q[CNT_W-1:XLEN];
            SEL_RET_LO:  rd_val_o = instret_q[XLEN-1:0];
            SEL_RET_HI:  rd_val_o = instret_q[CNT_W-1:XLEN];
            default:     rd_val_o = '0;
        endcase
    end

endmodule

/* csr_decode.sv */
module csr_decode
    import csr_cfg_pkg::*;
    import csr_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_i,
    input  logic [2:0]        funct3_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [IDX_W-1:0]  src_idx_i,
    input  logic [XLEN-1:0]   rs1_val_i,
    output logic              valid_o,
    output csr_kind_e         kind_o,
    output csr_sel_e          sel_o,
    output logic [XLEN-1:0]   operand_o,
    output logic              wr_o,
    output logic              illegal_o
);

    csr_kind_e       kind_d;
    csr_sel_e        sel_d;
    logic            imm_d;     // Immediate form
    logic            f3_ok;
    logic            addr_ok;
    logic            ro_d;      // User shadow
    logic            wr_d;
    logic            illegal_d;

    logic            valid_q;
    logic            wr_q;
    logic            illegal_q;
    csr_kind_e       kind_q;
    csr_sel_e        sel_q;
    logic [XLEN-1:0] operand_q;

    // funct3 to kind and operand source
    always_comb begin
        kind_d = KIND_WRITE;
        imm_d  = 1'b0;
        f3_ok  = 1'b1;
        case (funct3_i)
            F3_CSRRW:  kind_d = KIND_WRITE;
            F3_CSRRS:  kind_d = KIND_SET;
            F3_CSRRC:  kind_d = KIND_CLEAR;
            F3_CSRRWI: begin
                kind_d = KIND_WRITE;
                imm_d  = 1'b1;
            end
            F3_CSRRSI: begin
                kind_d = KIND_SET;
                imm_d  = 1'b1;
            end
            F3_CSRRCI: begin
                kind_d = KIND_CLEAR;
                imm_d  = 1'b1;
            end
            default:   f3_ok = 1'b0; // 0 and 4
        endcase
    end

    // Address to register select
    always_comb begin
        sel_d   = SEL_SCRATCH;
        addr_ok = 1'b1;
        ro_d    = 1'b0;
        case (addr_i)
            CSR_MSCRATCH:  sel_d = SEL_SCRATCH;
            CSR_MCYCLE:    sel_d = SEL_CYC_LO;
            CSR_MCYCLEH:   sel_d = SEL_CYC_HI;
            CSR_MINSTRET:  sel_d = SEL_RET_LO;
            CSR_MINSTRETH: sel_d = SEL_RET_HI;
            CSR_CYCLE: begin
                sel_d = SEL_CYC_LO;
                ro_d  = 1'b1;
            end
            CSR_CYCLEH: begin
                sel_d = SEL_CYC_HI;
                ro_d  = 1'b1;
            end
            CSR_INSTRET: begin
                sel_d = SEL_RET_LO;
                ro_d  = 1'b1;
            end
            CSR_INSTRETH: begin
                sel_d = SEL_RET_HI;
                ro_d  = 1'b1;
            end
            default:       addr_ok = 1'b0;
        endcase
    end

    // Set and clear from x0 or zimm 0 only read
    assign wr_d      = (kind_d == KIND_WRITE) || (src_idx_i != '0);
    assign illegal_d = !f3_ok || !addr_ok || (wr_d && ro_d);

    // Decode stage control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            wr_q      <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= req_i;
            wr_q      <= req_i && wr_d && !illegal_d; // Illegal never writes
            illegal_q <= req_i && illegal_d;
        end
    end

    // Decode stage payload
    always_ff @(posedge clk) begin
        if (req_i) begin
            kind_q    <= kind_d;
            sel_q     <= sel_d;
            operand_q <= imm_d ? {{(XLEN-IDX_W){1'b0}}, src_idx_i} : rs1_val_i;
        end
    end

    assign valid_o   = valid_q;
    assign kind_o    = kind_q;
    assign sel_o     = sel_q;
    assign operand_o = operand_q;
    assign wr_o      = wr_q;
    assign illegal_o = illegal_q;

endmodule

/* csr_isa_pkg.sv */
package csr_isa_pkg;

    import csr_cfg_pkg::*;

    // funct3 codes of the Zicsr group, 0 and 4 reserved
    localparam logic [2:0] F3_CSRRW  = 3'd1;
    localparam logic [2:0] F3_CSRRS  = 3'd2;
    localparam logic [2:0] F3_CSRRC  = 3'd3;
    localparam logic [2:0] F3_CSRRWI = 3'd5;
    localparam logic [2:0] F3_CSRRSI = 3'd6;
    localparam logic [2:0] F3_CSRRCI = 3'd7;

    // Machine scratch
    localparam logic [ADDR_W-1:0] CSR_MSCRATCH = 12'h340;

    // Machine counters, read-write
    localparam logic [ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [ADDR_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [ADDR_W-1:0] CSR_MINSTRETH = 12'hB82;

    // User shadows, read-only
    localparam logic [ADDR_W-1:0] CSR_CYCLE    = 12'hC00;
    localparam logic [ADDR_W-1:0] CSR_INSTRET  = 12'hC02;
    localparam logic [ADDR_W-1:0] CSR_CYCLEH   = 12'hC80;
    localparam logic [ADDR_W-1:0] CSR_INSTRETH = 12'hC82;

    // What the write does to the old value
    typedef enum logic [1:0] {
        KIND_WRITE,
        KIND_SET,
        KIND_CLEAR
    } csr_kind_e;

    // Physical register, shadows share the machine selects
    typedef enum logic [2:0] {
        SEL_SCRATCH,
        SEL_CYC_LO,
        SEL_CYC_HI,
        SEL_RET_LO,
        SEL_RET_HI
    } csr_sel_e;

endpackage

/* csr_cfg_pkg.sv */
package csr_cfg_pkg;

    // Register data word of the RV32 core
    localparam int unsigned XLEN = 32;

    // Cycle and instret counters span two words
    localparam int unsigned CNT_W = 2 * XLEN;

    // CSR address field of the instruction
    localparam int unsigned ADDR_W = 12;

    // rs1 index, doubles as zimm for immediate forms
    localparam int unsigned IDX_W = 5;

endpackage
